// ==== logic/mem_arb_macros.svh ====
`ifndef MEM_ARB_MACROS_SVH
`define MEM_ARB_MACROS_SVH

// Byte address width
`define MEM_ADDR_W 32

// Data width, strobe is one bit per byte
`define MEM_DATA_W 64

// Words in the SRAM
`define MEM_DEPTH 256

// Burst length field, 0 is one beat and 1 is two beats
`define MEM_LEN_W 1

`endif

// ==== logic/mem_arb_pkg.sv ====
package mem_arb_pkg;

    // Grant owner for both arbiters
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M1,
        ARB_M2
    } arb_state_e;

    // SRAM sequencer
    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_READ,
        SRAM_WRESP
    } sram_state_e;

    // AXI response encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } axi_resp_e;

endpackage

// ==== logic/axi_rd_if.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

interface axi_rd_if import mem_arb_pkg::*; ();

    logic                   ar_valid;
    logic                   ar_ready;
    logic [`MEM_ADDR_W-1:0] ar_addr;
    logic [`MEM_LEN_W-1:0]  ar_len;

    logic                   r_valid;
    logic                   r_ready;
    logic [`MEM_DATA_W-1:0] r_data;
    axi_resp_e              r_resp;
    logic                   r_last;

    modport master (
        output ar_valid, ar_addr, ar_len, r_ready,
        input  ar_ready, r_valid, r_data, r_resp, r_last
    );

    modport slave (
        input  ar_valid, ar_addr, ar_len, r_ready,
        output ar_ready, r_valid, r_data, r_resp, r_last
    );

endinterface

// ==== logic/axi_wr_if.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

interface axi_wr_if import mem_arb_pkg::*; ();

    logic                       aw_valid;
    logic                       aw_ready;
    logic [`MEM_ADDR_W-1:0]     aw_addr;

    logic                       w_valid;
    logic                       w_ready;
    logic [`MEM_DATA_W-1:0]     w_data;
    logic [`MEM_DATA_W/8-1:0]   w_strb;

    logic                       b_valid;
    logic                       b_ready;
    axi_resp_e                  b_resp;

    modport master (
        output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  aw_ready, w_ready, b_valid, b_resp
    );

    modport slave (
        input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        output aw_ready, w_ready, b_valid, b_resp
    );

endinterface

// ==== logic/read_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

module read_arbiter import mem_arb_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    m1_ar_valid_i,
    input  logic [`MEM_ADDR_W-1:0]  m1_ar_addr_i,
    input  logic [`MEM_LEN_W-1:0]   m1_ar_len_i,
    input  logic                    m1_r_ready_i,
    output logic                    m1_ar_ready_o,
    output logic                    m1_r_valid_o,
    output logic [`MEM_DATA_W-1:0]  m1_r_data_o,
    output axi_resp_e               m1_r_resp_o,
    output logic                    m1_r_last_o,

    input  logic                    m2_ar_valid_i,
    input  logic [`MEM_ADDR_W-1:0]  m2_ar_addr_i,
    input  logic [`MEM_LEN_W-1:0]   m2_ar_len_i,
    input  logic                    m2_r_ready_i,
    output logic                    m2_ar_ready_o,
    output logic                    m2_r_valid_o,
    output logic [`MEM_DATA_W-1:0]  m2_r_data_o,
    output axi_resp_e               m2_r_resp_o,
    output logic                    m2_r_last_o,

    axi_rd_if.master                mem
);

    arb_state_e grant_q;
    arb_state_e grant_d;
    logic       sel_m1;
    logic       sel_m2;
    logic       burst_done;

    assign sel_m1     = (grant_q == ARB_M1);
    assign sel_m2     = (grant_q == ARB_M2);
    assign burst_done = mem.r_valid & mem.r_ready & mem.r_last;

    // Fetch wins ties, grant passes on at burst end
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            ARB_IDLE: begin
                if (m1_ar_valid_i) begin
                    grant_d = ARB_M1;
                end else if (m2_ar_valid_i) begin
                    grant_d = ARB_M2;
                end
            end
            ARB_M1: begin
                if (burst_done) begin
                    grant_d = m2_ar_valid_i ? ARB_M2 : ARB_IDLE;
                end
            end
            ARB_M2: begin
                if (burst_done) begin
                    grant_d = m1_ar_valid_i ? ARB_M1 : ARB_IDLE;
                end
            end
            default: grant_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= ARB_IDLE;
        end else begin
            grant_q <= grant_d;
        end
    end

    assign mem.ar_valid = sel_m1 ? m1_ar_valid_i : (sel_m2 ? m2_ar_valid_i : 1'b0);
    assign mem.ar_addr  = sel_m2 ? m2_ar_addr_i : m1_ar_addr_i;
    assign mem.ar_len   = sel_m2 ? m2_ar_len_i : m1_ar_len_i;
    assign mem.r_ready  = sel_m1 ? m1_r_ready_i : (sel_m2 ? m2_r_ready_i : 1'b0);

    // Ungranted side sees nothing
    assign m1_ar_ready_o = sel_m1 & mem.ar_ready;
    assign m1_r_valid_o  = sel_m1 & mem.r_valid;
    assign m1_r_data_o   = sel_m1 ? mem.r_data : '0;
    assign m1_r_resp_o   = sel_m1 ? mem.r_resp : RESP_OKAY;
    assign m1_r_last_o   = sel_m1 & mem.r_last;

    assign m2_ar_ready_o = sel_m2 & mem.ar_ready;
    assign m2_r_valid_o  = sel_m2 & mem.r_valid;
    assign m2_r_data_o   = sel_m2 ? mem.r_data : '0;
    assign m2_r_resp_o   = sel_m2 ? mem.r_resp : RESP_OKAY;
    assign m2_r_last_o   = sel_m2 & mem.r_last;

    // A pending beat keeps its owner
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        mem.r_valid && !mem.r_ready |=> $stable(grant_q));

endmodule

// ==== logic/write_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

module write_arbiter import mem_arb_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        m1_aw_valid_i,
    input  logic [`MEM_ADDR_W-1:0]      m1_aw_addr_i,
    input  logic                        m1_w_valid_i,
    input  logic [`MEM_DATA_W-1:0]      m1_w_data_i,
    input  logic [`MEM_DATA_W/8-1:0]    m1_w_strb_i,
    input  logic                        m1_b_ready_i,
    output logic                        m1_aw_ready_o,
    output logic                        m1_w_ready_o,
    output logic                        m1_b_valid_o,
    output axi_resp_e                   m1_b_resp_o,

    input  logic                        m2_aw_valid_i,
    input  logic [`MEM_ADDR_W-1:0]      m2_aw_addr_i,
    input  logic                        m2_w_valid_i,
    input  logic [`MEM_DATA_W-1:0]      m2_w_data_i,
    input  logic [`MEM_DATA_W/8-1:0]    m2_w_strb_i,
    input  logic                        m2_b_ready_i,
    output logic                        m2_aw_ready_o,
    output logic                        m2_w_ready_o,
    output logic                        m2_b_valid_o,
    output axi_resp_e                   m2_b_resp_o,

    axi_wr_if.master                    mem
);

    arb_state_e grant_q;
    arb_state_e grant_d;
    logic       sel_m1;
    logic       sel_m2;
    logic       b_done;

    assign sel_m1 = (grant_q == ARB_M1);
    assign sel_m2 = (grant_q == ARB_M2);
    assign b_done = mem.b_valid & mem.b_ready;

    // Load/store wins ties
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            ARB_IDLE: begin
                if (m2_aw_valid_i) begin
                    grant_d = ARB_M2;
                end else if (m1_aw_valid_i) begin
                    grant_d = ARB_M1;
                end
            end
            ARB_M1: begin
                if (b_done) begin
                    grant_d = m2_aw_valid_i ? ARB_M2 : ARB_IDLE;
                end
            end
            ARB_M2: begin
                if (b_done) begin
                    grant_d = m1_aw_valid_i ? ARB_M1 : ARB_IDLE;
                end
            end
            default: grant_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= ARB_IDLE;
        end else begin
            grant_q <= grant_d;
        end
    end

    assign mem.aw_valid = sel_m1 ? m1_aw_valid_i : (sel_m2 ? m2_aw_valid_i : 1'b0);
    assign mem.aw_addr  = sel_m2 ? m2_aw_addr_i : m1_aw_addr_i;
    assign mem.w_valid  = sel_m1 ? m1_w_valid_i : (sel_m2 ? m2_w_valid_i : 1'b0);
    assign mem.w_data   = sel_m2 ? m2_w_data_i : m1_w_data_i;
    assign mem.w_strb   = sel_m2 ? m2_w_strb_i : m1_w_strb_i;
    assign mem.b_ready  = sel_m1 ? m1_b_ready_i : (sel_m2 ? m2_b_ready_i : 1'b0);

    assign m1_aw_ready_o = sel_m1 & mem.aw_ready;
    assign m1_w_ready_o  = sel_m1 & mem.w_ready;
    assign m1_b_valid_o  = sel_m1 & mem.b_valid;
    assign m1_b_resp_o   = sel_m1 ? mem.b_resp : RESP_OKAY;

    assign m2_aw_ready_o = sel_m2 & mem.aw_ready;
    assign m2_w_ready_o  = sel_m2 & mem.w_ready;
    assign m2_b_valid_o  = sel_m2 & mem.b_valid;
    assign m2_b_resp_o   = sel_m2 ? mem.b_resp : RESP_OKAY;

    // Controller only answers while a master owns the channel
    a_b_owned: assert property (@(posedge clk) disable iff (rst)
        mem.b_valid |-> grant_q != ARB_IDLE);

endmodule

// ==== logic/sram_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

module sram_ctrl import mem_arb_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    axi_rd_if.slave     rd,
    axi_wr_if.slave     wr
);

    localparam int BYTES = `MEM_DATA_W / 8;
    localparam int IDX_W = $clog2(`MEM_DEPTH);
    localparam int OFS_W = $clog2(BYTES);

    logic [`MEM_DATA_W-1:0] mem_q [`MEM_DEPTH];

    sram_state_e            state_q;
    logic                   ar_ready_q;
    logic                   aw_ready_q;
    logic                   rd_first_q;
    logic [`MEM_LEN_W-1:0]  len_q;
    logic [`MEM_LEN_W-1:0]  beat_q;
    logic [`MEM_ADDR_W-1:0] rd_addr_q;
    logic [`MEM_DATA_W-1:0] r_data_q;
    axi_resp_e              r_resp_q;
    axi_resp_e              b_resp_q;

    logic                   ar_hs;
    logic                   r_hs;
    logic                   wr_req;
    logic                   wr_hs;
    logic                   b_hs;
    logic                   last_beat;
    logic                   load_beat;
    logic                   beat_ok;
    logic                   wr_ok;
    logic [`MEM_ADDR_W-1:0] beat_addr;

    function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
        return addr < `MEM_ADDR_W'(`MEM_DEPTH * BYTES);
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(input logic [`MEM_ADDR_W-1:0] addr);
        return addr[OFS_W +: IDX_W];
    endfunction

    assign ar_hs     = rd.ar_valid & ar_ready_q;
    assign r_hs      = rd.r_valid & rd.r_ready;
    assign wr_req    = wr.aw_valid & wr.w_valid;
    assign wr_hs     = wr_req & aw_ready_q;
    assign b_hs      = wr.b_valid & wr.b_ready;
    assign last_beat = (beat_q == len_q);
    assign load_beat = ar_hs | (r_hs & ~last_beat);
    assign beat_addr = ar_hs ? rd.ar_addr : rd_addr_q + `MEM_ADDR_W'(BYTES);
    assign beat_ok   = in_range(beat_addr);
    assign wr_ok     = in_range(wr.aw_addr);

    assign rd.ar_ready = ar_ready_q;
    assign rd.r_valid  = (state_q == SRAM_READ);
    assign rd.r_data   = r_data_q;
    assign rd.r_resp   = r_resp_q;
    assign rd.r_last   = (state_q == SRAM_READ) & last_beat;
    assign wr.aw_ready = aw_ready_q;
    assign wr.w_ready  = aw_ready_q;
    assign wr.b_valid  = (state_q == SRAM_WRESP);
    assign wr.b_resp   = b_resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= SRAM_IDLE;
            ar_ready_q <= 1'b0;
            aw_ready_q <= 1'b0;
            rd_first_q <= 1'b0;
            len_q      <= '0;
            beat_q     <= '0;
        end else begin
            rd_first_q <= b_hs;
            case (state_q)
                SRAM_IDLE: begin
                    if (ar_hs) begin
                        ar_ready_q <= 1'b0;
                        len_q      <= rd.ar_len;
                        beat_q     <= '0;
                        state_q    <= SRAM_READ;
                    end else if (wr_hs) begin
                        aw_ready_q <= 1'b0;
                        state_q    <= SRAM_WRESP;
                    end else if (!ar_ready_q && !aw_ready_q) begin
                        // Writes first, except a read waiting just after a response
                        if (wr_req && !(rd_first_q && rd.ar_valid)) begin
                            aw_ready_q <= 1'b1;
                        end else if (rd.ar_valid) begin
                            ar_ready_q <= 1'b1;
                        end
                    end
                end
                SRAM_READ: begin
                    if (r_hs) begin
                        if (last_beat) begin
                            state_q <= SRAM_IDLE;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                SRAM_WRESP: begin
                    if (b_hs) begin
                        state_q <= SRAM_IDLE;
                    end
                end
                default: state_q <= SRAM_IDLE;
            endcase
        end
    end

    // Word array and response payload
    always_ff @(posedge clk) begin
        if (load_beat) begin
            rd_addr_q <= beat_addr;
            r_data_q  <= beat_ok ? mem_q[word_idx(beat_addr)] : '0;
            r_resp_q  <= beat_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_hs) begin
            b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            if (wr_ok) begin
                for (int i = 0; i < BYTES; i++) begin
                    if (wr.w_strb[i]) begin
                        mem_q[word_idx(wr.aw_addr)][8*i +: 8] <= wr.w_data[8*i +: 8];
                    end
                end
            end
        end
    end

    // No new address while a response is still pending
    a_one_txn: assert property (@(posedge clk) disable iff (rst)
        (rd.r_valid || wr.b_valid) |-> !rd.ar_ready && !wr.aw_ready);

    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        rd.r_valid && !rd.r_ready |=> $stable(rd.r_data));

endmodule

// ==== logic/mem_arb_top.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

module mem_arb_top import mem_arb_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    // Fetch unit
    input  logic                        m1_ar_valid_i,
    input  logic [`MEM_ADDR_W-1:0]      m1_ar_addr_i,
    input  logic [`MEM_LEN_W-1:0]       m1_ar_len_i,
    input  logic                        m1_r_ready_i,
    output logic                        m1_ar_ready_o,
    output logic                        m1_r_valid_o,
    output logic [`MEM_DATA_W-1:0]      m1_r_data_o,
    output axi_resp_e                   m1_r_resp_o,
    output logic                        m1_r_last_o,
    input  logic                        m1_aw_valid_i,
    input  logic [`MEM_ADDR_W-1:0]      m1_aw_addr_i,
    input  logic                        m1_w_valid_i,
    input  logic [`MEM_DATA_W-1:0]      m1_w_data_i,
    input  logic [`MEM_DATA_W/8-1:0]    m1_w_strb_i,
    input  logic                        m1_b_ready_i,
    output logic                        m1_aw_ready_o,
    output logic                        m1_w_ready_o,
    output logic                        m1_b_valid_o,
    output axi_resp_e                   m1_b_resp_o,

    // Load/store unit
    input  logic                        m2_ar_valid_i,
    input  logic [`MEM_ADDR_W-1:0]      m2_ar_addr_i,
    input  logic [`MEM_LEN_W-1:0]       m2_ar_len_i,
    input  logic                        m2_r_ready_i,
    output logic                        m2_ar_ready_o,
    output logic                        m2_r_valid_o,
    output logic [`MEM_DATA_W-1:0]      m2_r_data_o,
    output axi_resp_e                   m2_r_resp_o,
    output logic                        m2_r_last_o,
    input  logic                        m2_aw_valid_i,
    input  logic [`MEM_ADDR_W-1:0]      m2_aw_addr_i,
    input  logic                        m2_w_valid_i,
    input  logic [`MEM_DATA_W-1:0]      m2_w_data_i,
    input  logic [`MEM_DATA_W/8-1:0]    m2_w_strb_i,
    input  logic                        m2_b_ready_i,
    output logic                        m2_aw_ready_o,
    output logic                        m2_w_ready_o,
    output logic                        m2_b_valid_o,
    output axi_resp_e                   m2_b_resp_o
);

    axi_rd_if rd_bus ();
    axi_wr_if wr_bus ();

    read_arbiter u_rd_arb (.mem(rd_bus), .*);

    write_arbiter u_wr_arb (.mem(wr_bus), .*);

    sram_ctrl u_sram (
        .clk (clk),
        .rst (rst),
        .rd  (rd_bus),
        .wr  (wr_bus)
    );

endmodule

// ==== sim/mem_arb_tb.sv ====
`timescale 1ns/1ps
`include "mem_arb_macros.svh"

module mem_arb_tb;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;

    // Index 1 is the fetch unit, index 2 the load/store unit
    logic [2:1]                      ar_valid;
    logic [2:1][`MEM_ADDR_W-1:0]     ar_addr;
    logic [2:1][`MEM_LEN_W-1:0]      ar_len;
    logic [2:1]                      r_ready;
    logic [2:1]                      ar_ready;
    logic [2:1]                      r_valid;
    logic [2:1][`MEM_DATA_W-1:0]     r_data;
    logic [2:1][1:0]                 r_resp;
    logic [2:1]                      r_last;
    logic [2:1]                      aw_valid;
    logic [2:1][`MEM_ADDR_W-1:0]     aw_addr;
    logic [2:1]                      w_valid;
    logic [2:1][`MEM_DATA_W-1:0]     w_data;
    logic [2:1][`MEM_DATA_W/8-1:0]   w_strb;
    logic [2:1]                      b_ready;
    logic [2:1]                      aw_ready;
    logic [2:1]                      w_ready;
    logic [2:1]                      b_valid;
    logic [2:1][1:0]                 b_resp;

    integer seed;
    int     checks;
    int     errors;
    int     timeouts;

    mem_arb_top uut (
        .clk           (clk),
        .rst           (rst),
        .m1_ar_valid_i (ar_valid[1]), .m2_ar_valid_i (ar_valid[2]),
        .m1_ar_addr_i  (ar_addr[1]),  .m2_ar_addr_i  (ar_addr[2]),
        .m1_ar_len_i   (ar_len[1]),   .m2_ar_len_i   (ar_len[2]),
        .m1_r_ready_i  (r_ready[1]),  .m2_r_ready_i  (r_ready[2]),
        .m1_ar_ready_o (ar_ready[1]), .m2_ar_ready_o (ar_ready[2]),
        .m1_r_valid_o  (r_valid[1]),  .m2_r_valid_o  (r_valid[2]),
        .m1_r_data_o   (r_data[1]),   .m2_r_data_o   (r_data[2]),
        .m1_r_resp_o   (r_resp[1]),   .m2_r_resp_o   (r_resp[2]),
        .m1_r_last_o   (r_last[1]),   .m2_r_last_o   (r_last[2]),
        .m1_aw_valid_i (aw_valid[1]), .m2_aw_valid_i (aw_valid[2]),
        .m1_aw_addr_i  (aw_addr[1]),  .m2_aw_addr_i  (aw_addr[2]),
        .m1_w_valid_i  (w_valid[1]),  .m2_w_valid_i  (w_valid[2]),
        .m1_w_data_i   (w_data[1]),   .m2_w_data_i   (w_data[2]),
        .m1_w_strb_i   (w_strb[1]),   .m2_w_strb_i   (w_strb[2]),
        .m1_b_ready_i  (b_ready[1]),  .m2_b_ready_i  (b_ready[2]),
        .m1_aw_ready_o (aw_ready[1]), .m2_aw_ready_o (aw_ready[2]),
        .m1_w_ready_o  (w_ready[1]),  .m2_w_ready_o  (w_ready[2]),
        .m1_b_valid_o  (b_valid[1]),  .m2_b_valid_o  (b_valid[2]),
        .m1_b_resp_o   (b_resp[1]),   .m2_b_resp_o   (b_resp[2])
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, act, exp);
        end
    endtask

    // One read burst, called on a falling edge
    task automatic read_burst(input int m, input logic [31:0] addr, input logic [0:0] len,
                              input logic [63:0] exp0, input logic [63:0] exp1,
                              input logic [1:0] resp, input bit want_lat,
                              output time first_t, output time last_t);
        int waited;
        int cycles;
        int beats;
        int nbeats;
        bit ar_open;
        bit ar_drop;
        bit seen;
        bit take;
        waited = 0;
        cycles = 0;
        beats = 0;
        nbeats = int'(len) + 1;
        ar_open = 1'b1;
        ar_drop = 1'b0;
        seen = 1'b0;
        first_t = 0;
        last_t = 0;
        ar_valid[m] = 1'b1;
        ar_addr[m] = addr;
        ar_len[m] = len;
        while (beats < nbeats && waited < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            waited++;
            if (ar_drop) begin
                ar_valid[m] = 1'b0;
                ar_drop = 1'b0;
            end
            // Address taken on the coming rising edge
            if (ar_open && ar_ready[m]) begin
                ar_open = 1'b0;
                ar_drop = 1'b1;
            end
            r_ready[m] = 1'b0;
            if (r_valid[m]) begin
                if (!seen) begin
                    seen = 1'b1;
                    first_t = $time;
                    if (want_lat) begin
                        check($sformatf("m%0d_r_valid latency", m), 64'(cycles), 64'd3);
                    end
                end
                take = ($random(seed) & 3) != 0;
                r_ready[m] = take;
                if (take) begin
                    check($sformatf("m%0d_r_data", m), r_data[m], beats == 0 ? exp0 : exp1);
                    check($sformatf("m%0d_r_resp", m), 64'(r_resp[m]), 64'(resp));
                    check($sformatf("m%0d_r_last", m), 64'(r_last[m]),
                          64'(beats == nbeats - 1));
                    beats++;
                    waited = 0;
                    last_t = $time;
                end
            end
        end
        if (beats < nbeats) begin
            $display("Timeout: m%0d read of %h got no response in time", m, addr);
            timeouts++;
            ar_valid[m] = 1'b0;
        end
        @(negedge clk);
        r_ready[m] = 1'b0;
    endtask

    // One single-beat write, called on a falling edge
    task automatic write_word(input int m, input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb, input logic [1:0] resp,
                              output time done_t);
        int waited;
        bit aw_open;
        bit aw_drop;
        bit done;
        bit take;
        waited = 0;
        aw_open = 1'b1;
        aw_drop = 1'b0;
        done = 1'b0;
        done_t = 0;
        aw_valid[m] = 1'b1;
        w_valid[m] = 1'b1;
        aw_addr[m] = addr;
        w_data[m] = data;
        w_strb[m] = strb;
        while (!done && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (aw_drop) begin
                aw_valid[m] = 1'b0;
                w_valid[m] = 1'b0;
                aw_drop = 1'b0;
            end
            if (aw_open && aw_ready[m]) begin
                check($sformatf("m%0d_w_ready", m), 64'(w_ready[m]), 64'd1);
                aw_open = 1'b0;
                aw_drop = 1'b1;
            end
            b_ready[m] = 1'b0;
            if (b_valid[m]) begin
                take = ($random(seed) & 3) != 0;
                b_ready[m] = take;
                if (take) begin
                    check($sformatf("m%0d_b_resp", m), 64'(b_resp[m]), 64'(resp));
                    done = 1'b1;
                    done_t = $time;
                end
            end
        end
        if (!done) begin
            $display("Timeout: m%0d write to %h got no response in time", m, addr);
            timeouts++;
            aw_valid[m] = 1'b0;
            w_valid[m] = 1'b0;
        end
        @(negedge clk);
        b_ready[m] = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [0:0]  len;
        logic [63:0] wdata;
        logic [7:0]  strb;
        logic [63:0] exp0;
        logic [63:0] exp1;
        logic [1:0]  resp;
        time         t1a;
        time         t1b;
        time         t2a;
        time         t2b;
        seed = 32'hccac;
        checks = 0;
        errors = 0;
        timeouts = 0;
        rst = 1'b1;
        ar_valid = '0;
        ar_addr = '0;
        ar_len = '0;
        r_ready = '0;
        aw_valid = '0;
        aw_addr = '0;
        w_valid = '0;
        w_data = '0;
        w_strb = '0;
        b_ready = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/mem_arb_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file sim/mem_arb_tests.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd) && timeouts == 0) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        op, addr, len, wdata, strb, exp0, exp1, resp);
            if (n == 8) begin
                case (op)
                    4'h0: read_burst(1, addr, len, exp0, exp1, resp, 1'b1, t1a, t1b);
                    4'h1: read_burst(2, addr, len, exp0, exp1, resp, 1'b1, t2a, t2b);
                    4'h2: write_word(1, addr, wdata, strb, resp, t1a);
                    4'h3: write_word(2, addr, wdata, strb, resp, t2a);
                    4'h4: begin
                        fork
                            read_burst(1, addr, len, exp0, exp1, resp, 1'b0, t1a, t1b);
                            read_burst(2, addr, len, exp0, exp1, resp, 1'b0, t2a, t2b);
                        join
                        // Fetch burst must finish before load/store data starts
                        check("m2_r_valid order", 64'(t2a > t1b), 64'd1);
                    end
                    4'h5: begin
                        fork
                            write_word(1, addr + 32'd8, wdata, strb, resp, t1a);
                            write_word(2, addr, wdata, strb, resp, t2a);
                        join
                        check("m1_b_valid order", 64'(t1a > t2a), 64'd1);
                    end
                    default: begin
                        $display("Unknown operation code %h in the test vector file", op);
                        errors++;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim/mem_arb_tests.txt ====
# op addr len wdata strb exp0 exp1 resp, all fields hex
# op 0/1 read m1/m2, 2/3 write m1/m2, 4 both read, 5 both write (m2 at addr, m1 at addr+8)
2 00000000 0 1111111111111111 ff 0000000000000000 0000000000000000 0
3 00000008 0 2222222222222222 ff 0000000000000000 0000000000000000 0
0 00000000 1 0000000000000000 00 1111111111111111 2222222222222222 0
3 00000000 0 aaaaaaaaaaaaaaaa 0f 0000000000000000 0000000000000000 0
1 00000000 0 0000000000000000 00 11111111aaaaaaaa 0000000000000000 0
2 00000008 0 bbbbbbbbbbbbbbbb f0 0000000000000000 0000000000000000 0
4 00000000 1 0000000000000000 00 11111111aaaaaaaa bbbbbbbb22222222 0
5 00000100 0 0123456789abcdef ff 0000000000000000 0000000000000000 0
0 00000100 1 0000000000000000 00 0123456789abcdef 0123456789abcdef 0
2 00000800 0 deadbeefdeadbeef ff 0000000000000000 0000000000000000 2
1 00000800 0 0000000000000000 00 0000000000000000 0000000000000000 2
0 00000000 0 0000000000000000 00 11111111aaaaaaaa 0000000000000000 0
3 000007f8 0 5555666677778888 ff 0000000000000000 0000000000000000 0
1 000007f8 0 0000000000000000 00 5555666677778888 0000000000000000 0

// ==== mem_arb_top.f ====
+incdir+logic
logic/mem_arb_pkg.sv
logic/axi_rd_if.sv
logic/axi_wr_if.sv
logic/read_arbiter.sv
logic/write_arbiter.sv
logic/sram_ctrl.sv
logic/mem_arb_top.sv
sim/mem_arb_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module mem_arb_top -f mem_arb_top.f

sim:
	verilator --binary --timing --assert --top-module mem_arb_tb -f mem_arb_top.f -o mem_arb_sim
	./obj_dir/mem_arb_sim | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
